// File: rtl/ising_pkg.sv
// shared sizes, host address map and weight encoding
// plus the spin pair to memory entry mapping

package ising_pkg;

    // ------------------------------------------------------------------------
    // sizes
    // ------------------------------------------------------------------------
    localparam int n_spins     = 8;
    localparam int num_pairs   = n_spins * (n_spins - 1) / 2;   // 28 entries
    localparam int spin_w      = $clog2(n_spins);
    localparam int num_weights = 5;                             // odd, one-hot
    localparam int field_w     = 6;
    localparam int pair_w      = 5;

    // middle bit set means coupling 0
    localparam logic [num_weights-1:0] weight_zero = num_weights'(1) << (num_weights / 2);

    localparam logic [15:0] lfsr_seed = 16'hace1;

    // ------------------------------------------------------------------------
    // host address map, 4 byte stride
    // ------------------------------------------------------------------------
    localparam logic [31:0] start_addr       = 32'h0000_0500;
    localparam logic [31:0] ctr_cutoff_addr  = 32'h0000_0600;
    localparam logic [31:0] ctr_max_addr     = 32'h0000_0700;
    localparam logic [31:0] phase_addr_base  = 32'h0000_0800;
    localparam logic [31:0] weight_addr_base = 32'h0000_1000;

    // entry of pair (a, b), a != b, order does not matter
    // rows of the upper triangle are packed one after another
    function automatic logic [pair_w-1:0] pair_index(input int a, input int b);
        int lo;
        int hi;
        lo = (a < b) ? a : b;
        hi = (a < b) ? b : a;
        return pair_w'(lo * (2 * n_spins - lo - 1) / 2 + (hi - lo - 1));
    endfunction

endpackage

// File: rtl/weight_ram.sv
// single port coupling weight memory, one cycle read latency

`timescale 1ns/1ps

module weight_ram (
    input  logic                              clk,
    input  logic                              axi_rstn,
    input  logic                              mem_en,
    input  logic                              mem_we,
    input  logic [ising_pkg::pair_w-1:0]      mem_addr,
    input  logic [ising_pkg::num_weights-1:0] mem_wdata,
    output logic [ising_pkg::num_weights-1:0] rd_data
);
    import ising_pkg::*;

    logic [num_weights-1:0] mem [num_pairs];

    always_ff @(posedge clk) begin
        if (!axi_rstn) begin
            for (int p = 0; p < num_pairs; p++)
                mem[p] <= weight_zero;              // all couplings 0
            rd_data <= weight_zero;
        end else if (mem_en) begin
            if (mem_we)
                mem[mem_addr] <= mem_wdata;
            else
                rd_data <= mem[mem_addr];
        end
    end

endmodule

// File: rtl/weight_arbiter.sv
// weight memory port arbiter, host writes win over engine reads

`timescale 1ns/1ps

module weight_arbiter (
    input  logic                              clk,
    input  logic                              axi_rstn,
    input  logic                              host_we,
    input  logic [ising_pkg::pair_w-1:0]      host_addr,
    input  logic [ising_pkg::num_weights-1:0] host_wdata,
    input  logic                              eng_req,
    input  logic [ising_pkg::pair_w-1:0]      eng_addr,
    output logic                              eng_gnt,
    output logic                              mem_en,
    output logic                              mem_we,
    output logic [ising_pkg::pair_w-1:0]      mem_addr,
    output logic [ising_pkg::num_weights-1:0] mem_wdata
);

    logic eng_win;

    assign eng_win   = eng_req && !host_we;
    assign mem_en    = host_we || eng_req;
    assign mem_we    = host_we;
    assign mem_addr  = host_we ? host_addr : eng_addr;
    assign mem_wdata = host_wdata;

    // lines up with the memory read latency
    always_ff @(posedge clk) begin
        if (!axi_rstn)
            eng_gnt <= 1'b0;
        else
            eng_gnt <= eng_win;
    end

endmodule

// File: rtl/spin_engine.sv
// sequential spin update engine
// local field accumulation, random or greedy update, sweep counting

`timescale 1ns/1ps

module spin_engine (
    input  logic                              clk,
    input  logic                              rstn,
    input  logic [31:0]                       counter_cutoff,
    input  logic [31:0]                       counter_max,
    input  logic                              eng_gnt,    // rd_data valid this cycle
    input  logic [ising_pkg::num_weights-1:0] rd_data,
    output logic                              eng_req,
    output logic [ising_pkg::pair_w-1:0]      eng_addr,
    output logic [ising_pkg::n_spins-1:0]     phase,
    output logic                              done
);
    import ising_pkg::*;

    logic [spin_w-1:0]         spin_idx;    // spin being updated
    logic [spin_w-1:0]         nb_idx;      // neighbour slot of the data in flight
    logic [spin_w-1:0]         nb_req;
    logic [spin_w-1:0]         data_spin;
    logic                      busy;
    logic                      upd_cyc;
    logic                      last_nb;
    logic                      last_spin;
    logic [31:0]               sweep_cnt;
    logic [31:0]               sweep_nxt;
    logic signed [field_w-1:0] field;
    logic signed [field_w-1:0] weight_c;
    logic signed [field_w-1:0] term;
    logic [15:0]               lfsr;
    logic                      lfsr_fb;

    // slot k skips the spin itself
    function automatic int neighbour(input int spin, input int slot);
        return (slot < spin) ? slot : slot + 1;
    endfunction

    // one-hot bit k gives coupling k - num_weights/2
    function automatic logic signed [field_w-1:0] coupling(input logic [num_weights-1:0] w);
        logic signed [field_w-1:0] c;
        c = '0;
        for (int k = 0; k < num_weights; k++) begin
            if (w[k])
                c = field_w'(k - num_weights / 2);
        end
        return c;
    endfunction

    // ------------------------------------------------------------------------
    // weight requests
    // ------------------------------------------------------------------------
    assign last_nb   = (nb_idx == spin_w'(n_spins - 2));
    assign last_spin = (spin_idx == spin_w'(n_spins - 1));

    // a returned read moves the request on to the next slot at once
    assign nb_req   = eng_gnt ? nb_idx + 1'b1 : nb_idx;
    assign eng_addr = pair_index(int'(spin_idx), neighbour(int'(spin_idx), int'(nb_req)));
    assign eng_req  = busy && !upd_cyc && !(eng_gnt && last_nb);

    // ------------------------------------------------------------------------
    // field and update
    // ------------------------------------------------------------------------
    assign data_spin = spin_w'(neighbour(int'(spin_idx), int'(nb_idx)));
    assign weight_c  = coupling(rd_data);
    assign term      = phase[data_spin] ? weight_c : -weight_c;
    assign sweep_nxt = sweep_cnt + 32'd1;
    assign lfsr_fb   = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];

    always_ff @(posedge clk) begin
        if (!rstn) begin
            spin_idx  <= '0;
            nb_idx    <= '0;
            busy      <= 1'b0;
            upd_cyc   <= 1'b0;
            done      <= 1'b0;
            sweep_cnt <= '0;
            field     <= '0;
            phase     <= '0;
            lfsr      <= lfsr_seed;
        end else if (!done) begin
            if (!busy) begin
                // one idle cycle so no stale grant is seen
                if (sweep_cnt >= counter_max)
                    done <= 1'b1;
                else
                    busy <= 1'b1;
            end else if (!upd_cyc) begin
                if (eng_gnt) begin
                    field <= field + term;
                    if (last_nb)
                        upd_cyc <= 1'b1;
                    else
                        nb_idx <= nb_idx + 1'b1;
                end
            end else begin
                if (sweep_cnt < counter_cutoff)
                    phase[spin_idx] <= lfsr[0];     // annealing phase
                else if (field > 0)
                    phase[spin_idx] <= 1'b1;
                else if (field < 0)
                    phase[spin_idx] <= 1'b0;        // zero field keeps the spin
                lfsr     <= {lfsr[14:0], lfsr_fb};
                field    <= '0;
                nb_idx   <= '0;
                upd_cyc  <= 1'b0;
                spin_idx <= spin_idx + 1'b1;
                if (last_spin) begin
                    sweep_cnt <= sweep_nxt;
                    if (sweep_nxt >= counter_max) begin
                        busy <= 1'b0;
                        done <= 1'b1;
                    end
                end
            end
        end
    end

endmodule

// File: rtl/top_ising.sv
// Ising core
// spin engine and host writes sharing one weight memory

`timescale 1ns/1ps

module top_ising (
    input  logic                              clk,
    input  logic                              axi_rstn,   // memory and arbiter
    input  logic                              rstn,       // engine only
    input  logic [31:0]                       counter_cutoff,
    input  logic [31:0]                       counter_max,
    input  logic                              host_we,
    input  logic [ising_pkg::pair_w-1:0]      host_addr,
    input  logic [ising_pkg::num_weights-1:0] host_wdata,
    output logic [ising_pkg::n_spins-1:0]     phase,
    output logic                              done
);
    import ising_pkg::*;

    logic                   eng_req;
    logic [pair_w-1:0]      eng_addr;
    logic                   eng_gnt;
    logic                   mem_en;
    logic                   mem_we;
    logic [pair_w-1:0]      mem_addr;
    logic [num_weights-1:0] mem_wdata;
    logic [num_weights-1:0] rd_data;

    spin_engine u_spin_engine (
        .clk            (clk),
        .rstn           (rstn),
        .counter_cutoff (counter_cutoff),
        .counter_max    (counter_max),
        .eng_gnt        (eng_gnt),
        .rd_data        (rd_data),
        .eng_req        (eng_req),
        .eng_addr       (eng_addr),
        .phase          (phase),
        .done           (done)
    );

    weight_arbiter u_weight_arbiter (
        .clk        (clk),
        .axi_rstn   (axi_rstn),
        .host_we    (host_we),
        .host_addr  (host_addr),
        .host_wdata (host_wdata),
        .eng_req    (eng_req),
        .eng_addr   (eng_addr),
        .eng_gnt    (eng_gnt),
        .mem_en     (mem_en),
        .mem_we     (mem_we),
        .mem_addr   (mem_addr),
        .mem_wdata  (mem_wdata)
    );

    weight_ram u_weight_ram (
        .clk       (clk),
        .axi_rstn  (axi_rstn),
        .mem_en    (mem_en),
        .mem_we    (mem_we),
        .mem_addr  (mem_addr),
        .mem_wdata (mem_wdata),
        .rd_data   (rd_data)
    );

endmodule

// File: rtl/ising_axi.sv
// host register wrapper of the Ising accelerator
// control registers, write decode and the read response channel

`timescale 1ns/1ps

module ising_axi (
    input  logic        clk,
    input  logic        axi_rstn,

    // read port
    input  logic        arvalid_q,
    input  logic [31:0] araddr_q,
    input  logic        rready,
    output logic        rvalid,
    output logic        rresp,
    output logic [31:0] rdata,

    // write port, single cycle strobe
    input  logic        wready,
    input  logic [31:0] wr_addr,
    input  logic [31:0] wdata
);
    import ising_pkg::*;

    logic [31:0]            counter_cutoff;
    logic [31:0]            counter_max;
    logic                   start_bit;
    logic                   start_d;
    logic                   core_rstn;
    logic [n_spins-1:0]     phase;
    logic                   done;

    logic                   host_we;
    logic [pair_w-1:0]      host_addr;
    logic [num_weights-1:0] host_wdata;
    logic [31:0]            wr_off;

    logic [31:0]            rd_off;
    logic [31:0]            rd_word;
    logic                   rd_err;

    // ------------------------------------------------------------------------
    // write decode
    // ------------------------------------------------------------------------
    assign wr_off     = wr_addr - weight_addr_base;
    assign host_we    = wready && (wr_off < 32'(4 * num_pairs)) && (wr_off[1:0] == 2'b00);
    assign host_addr  = wr_off[2 +: pair_w];
    assign host_wdata = wdata[num_weights-1:0];

    always_ff @(posedge clk) begin
        if (!axi_rstn) begin
            counter_cutoff <= '0;
            counter_max    <= '0;
            start_bit      <= 1'b0;
            start_d        <= 1'b0;
        end else begin
            start_d <= start_bit;
            if (wready && wr_addr == start_addr)
                start_bit <= wdata[0];
            if (wready && wr_addr == ctr_cutoff_addr)
                counter_cutoff <= wdata;
            if (wready && wr_addr == ctr_max_addr)
                counter_max <= wdata;
        end
    end

    // core stays in reset one extra cycle after start rises
    assign core_rstn = start_bit && start_d;

    // ------------------------------------------------------------------------
    // read channel
    // ------------------------------------------------------------------------
    assign rd_off = araddr_q - phase_addr_base;

    always_comb begin
        rd_word = '0;
        rd_err  = 1'b0;
        if (araddr_q == start_addr)
            rd_word[0] = done;                      // status word
        else if (rd_off < 32'(4 * n_spins) && rd_off[1:0] == 2'b00)
            rd_word[0] = phase[rd_off[2 +: spin_w]];
        else
            rd_err = 1'b1;                          // unmapped
    end

    always_ff @(posedge clk) begin
        if (!axi_rstn) begin
            rvalid <= 1'b0;
            rresp  <= 1'b0;
            rdata  <= '0;
        end else if (rvalid && rready) begin
            rvalid <= 1'b0;
            rresp  <= 1'b0;
            rdata  <= '0;
        end else if (arvalid_q && !rvalid) begin  // held until rready
            rvalid <= 1'b1;
            rresp  <= rd_err;
            rdata  <= rd_word;
        end
    end

    top_ising u_top_ising (
        .clk            (clk),
        .axi_rstn       (axi_rstn),
        .rstn           (core_rstn),
        .counter_cutoff (counter_cutoff),
        .counter_max    (counter_max),
        .host_we        (host_we),
        .host_addr      (host_addr),
        .host_wdata     (host_wdata),
        .phase          (phase),
        .done           (done)
    );

endmodule

// File: dv/ising_tb.sv
// testbench of the Ising accelerator
// host read and write tasks, coupling model, run checks and watchdog

`timescale 1ns/1ps

module ising_tb;
    import ising_pkg::*;

    localparam int runs            = 4;
    localparam int longest_max     = 74;
    localparam int longest_cutoff  = 10;
    localparam int watchdog_cycles = runs * (longest_max + longest_cutoff) * n_spins * 12 + 20000;

    logic        clk = 1'b0;
    logic        axi_rstn;
    logic        arvalid_q;
    logic [31:0] araddr_q;
    logic        rready;
    logic        rvalid;
    logic        rresp;
    logic [31:0] rdata;
    logic        wready;
    logic [31:0] wr_addr;
    logic [31:0] wdata;

    integer      seed = 32'h43b1_7799;
    int          coup [n_spins][n_spins];   // symmetric model of the written couplings

    always #4 clk = ~clk;

    ising_axi ising_axi_inst (
        .clk       (clk),
        .axi_rstn  (axi_rstn),
        .arvalid_q (arvalid_q),
        .araddr_q  (araddr_q),
        .rready    (rready),
        .rvalid    (rvalid),
        .rresp     (rresp),
        .rdata     (rdata),
        .wready    (wready),
        .wr_addr   (wr_addr),
        .wdata     (wdata)
    );

    task automatic fail_check(input string msg);
        $display("Mismatch at time %0t: %s", $time, msg);
        $display("Done: errors found");
        $fatal(1);
    endtask

    // ------------------------------------------------------------------------
    // read channel protocol
    // ------------------------------------------------------------------------
    hold_check: assert property (@(posedge clk) disable iff (!axi_rstn)
        rvalid && !rready |=> rvalid && $stable(rdata) && $stable(rresp))
        else fail_check("read response changed while rready was low");

    clear_check: assert property (@(posedge clk) disable iff (!axi_rstn)
        rvalid && rready |=> !rvalid)
        else fail_check("rvalid still high after the handshake");

    // upper triangle entries counted row by row
    function automatic int entry_of(input int a, input int b);
        int idx;
        idx = 0;
        for (int lo = 0; lo < n_spins; lo++) begin
            for (int hi = lo + 1; hi < n_spins; hi++) begin
                if ((lo == a && hi == b) || (lo == b && hi == a))
                    return idx;
                idx++;
            end
        end
        return -1;
    endfunction

    function automatic logic [31:0] one_hot(input int c);
        return 32'(1) << (c + num_weights / 2);     // bit k is coupling k - 2
    endfunction

    function automatic int rand_coupling();
        int r;
        r = $random(seed) & 32'h7fff_ffff;
        return r % num_weights - num_weights / 2;
    endfunction

    task automatic write_reg(input logic [31:0] addr, input logic [31:0] data);
        @(posedge clk);
        wready  <= 1'b1;
        wr_addr <= addr;
        wdata   <= data;
        @(posedge clk);
        wready  <= 1'b0;
    endtask

    task automatic read_reg(input logic [31:0] addr, output logic [31:0] data,
                            output logic resp);
        int hold;
        hold = $random(seed) & 7;                   // random back-pressure
        @(posedge clk);
        arvalid_q <= 1'b1;
        araddr_q  <= addr;
        @(posedge clk);
        arvalid_q <= 1'b0;
        @(negedge clk);
        assert (rvalid) else fail_check("rvalid did not rise one cycle after the strobe");
        data = rdata;
        resp = rresp;
        repeat (hold) @(posedge clk);
        @(posedge clk);
        rready <= 1'b1;
        @(posedge clk);
        rready <= 1'b0;
    endtask

    task automatic set_weight(input int i, input int j, input int c);
        coup[i][j] = c;
        coup[j][i] = c;
        write_reg(weight_addr_base + 32'(4 * entry_of(i, j)), one_hot(c));
    endtask

    task automatic wait_done();
        logic [31:0] data;
        logic        resp;
        data = '0;
        while (data[0] !== 1'b1)
            read_reg(start_addr, data, resp);
    endtask

    // every spin agrees with the sign of its field, zero field skipped
    task automatic check_local_min(output logic [n_spins-1:0] ph);
        logic [31:0] data;
        logic        resp;
        int          f;
        for (int i = 0; i < n_spins; i++) begin
            read_reg(phase_addr_base + 32'(4 * i), data, resp);
            assert (resp == 1'b0) else fail_check($sformatf("rresp set on phase %0d", i));
            ph[i] = data[0];
        end
        for (int i = 0; i < n_spins; i++) begin
            f = 0;
            for (int j = 0; j < n_spins; j++)
                if (j != i)
                    f += ph[j] ? coup[i][j] : -coup[i][j];
            assert (f == 0 || ph[i] == (f > 0))
                else fail_check($sformatf("spin %0d is %0b with field %0d", i, ph[i], f));
        end
    endtask

    task automatic start_run(input int cutoff, input int max);
        write_reg(ctr_cutoff_addr, 32'(cutoff));
        write_reg(ctr_max_addr, 32'(max));
        write_reg(start_addr, 32'd1);
    endtask

    // ------------------------------------------------------------------------
    // main sequence
    // ------------------------------------------------------------------------
    initial begin
        logic [31:0]        data;
        logic               resp;
        logic [n_spins-1:0] ph;
        logic [n_spins-1:0] p;
        int                 a;
        int                 b;

        axi_rstn  <= 1'b0;
        arvalid_q <= 1'b0;
        araddr_q  <= '0;
        rready    <= 1'b0;
        wready    <= 1'b0;
        wr_addr   <= '0;
        wdata     <= '0;
        repeat (2) @(posedge clk);
        axi_rstn  <= 1'b1;

        // idle state
        read_reg(start_addr, data, resp);
        assert (data == 0 && resp == 0) else fail_check("done or rresp set before start");
        for (int i = 0; i < n_spins; i++) begin
            read_reg(phase_addr_base + 32'(4 * i), data, resp);
            assert (data == 0 && resp == 0) else fail_check("phase not 0 after reset");
        end
        read_reg(32'h0000_0900, data, resp);
        assert (data == 0 && resp == 1) else fail_check("unmapped read not flagged");
        read_reg(ctr_max_addr, data, resp);
        assert (data == 0 && resp == 1) else fail_check("write-only register not flagged");

        // greedy run on random couplings
        for (int i = 0; i < n_spins; i++)
            for (int j = i + 1; j < n_spins; j++)
                set_weight(i, j, rand_coupling());
        start_run(0, 64);
        wait_done();
        check_local_min(ph);

        // pattern couplings, only p and its complement are minima
        write_reg(start_addr, 32'd0);
        p = n_spins'($random(seed));
        for (int i = 0; i < n_spins; i++)
            for (int j = i + 1; j < n_spins; j++)
                set_weight(i, j, (p[i] == p[j]) ? 2 : -2);
        start_run(0, 64);
        wait_done();
        check_local_min(ph);
        assert (ph == p || ph == ~p)
            else fail_check($sformatf("phase %b for pattern %b", ph, p));

        // annealing, rewrites while the engine reads, then restart
        write_reg(start_addr, 32'd0);
        for (int i = 0; i < n_spins; i++)
            for (int j = i + 1; j < n_spins; j++)
                set_weight(i, j, rand_coupling());
        start_run(longest_cutoff, longest_max);
        repeat (4) begin
            a = $random(seed) & 7;
            b = (a + 1 + (($random(seed) & 32'h7fff_ffff) % (n_spins - 1))) % n_spins;
            set_weight(a, b, rand_coupling());
        end
        wait_done();
        check_local_min(ph);
        write_reg(start_addr, 32'd0);
        read_reg(start_addr, data, resp);
        assert (data == 0) else fail_check("done still set after start cleared");
        write_reg(start_addr, 32'd1);
        wait_done();
        check_local_min(ph);

        $display("Done: no errors");
        $finish;
    end

    initial begin
        repeat (watchdog_cycles) @(posedge clk);
        $display("Timeout: the run never finished within %0d cycles", watchdog_cycles);
        $display("Done: errors found");
        $fatal(1);
    end

endmodule

// File: ising_axi.f
rtl/ising_pkg.sv
rtl/weight_ram.sv
rtl/weight_arbiter.sv
rtl/spin_engine.sv
rtl/top_ising.sv
rtl/ising_axi.sv
dv/ising_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# build with Verilator and run, exit status follows the simulation

cd "$(dirname "$0")" &&
verilator --binary --timing --assert -j 0 --top-module ising_tb -Mdir obj_dir -f ising_axi.f &&
./obj_dir/Vising_tb ||
{ echo "simulation build or run failed"; exit 1; }
